//--- Bender.yml
package:
  name: rgb2hsv

sources:
  - logic/hsv_pkg.sv
  - logic/serial_divider.sv
  - logic/hsv_lane.sv
  - logic/hsv_stream_ctrl.sv
  - logic/rgb2hsv.sv
  - target: test
    include_dirs:
      - sim
    files:
      - sim/tb_rgb2hsv.sv

//--- compile.f
+incdir+sim
logic/hsv_pkg.sv
logic/serial_divider.sv
logic/hsv_lane.sv
logic/hsv_stream_ctrl.sv
logic/rgb2hsv.sv
sim/tb_rgb2hsv.sv

//--- logic/hsv_lane.sv
`timescale 1ns/100ps

module hsv_lane (
    input  logic                      clk_sys,
    input  logic                      reset_sys,
    input  logic [hsv_pkg::PIX_W-1:0] in_data,
    input  logic                      load_r,
    input  logic                      load_g,
    input  logic                      load_b,
    output logic [hsv_pkg::PIX_W-1:0] hue,
    output logic [hsv_pkg::PIX_W-1:0] sat,
    output logic [hsv_pkg::PIX_W-1:0] val
);
    import hsv_pkg::*;

    logic [PIX_W-1:0]       r_q;
    logic [PIX_W-1:0]       g_q;
    logic [PIX_W-1:0]       b_q;
    logic                   start;
    logic                   max_is_r;
    logic                   max_is_g;
    logic [PIX_W-1:0]       max_c;
    logic [PIX_W-1:0]       min_c;
    logic [PIX_W-1:0]       range;
    logic                   dir;
    logic [PIX_W-1:0]       diff_abs;
    logic [DIVIDEND_W-1:0]  hue_dvd;
    logic [PIX_W-1:0]       hue_dvs;
    logic [DIVIDEND_W-1:0]  sat_dvd;
    logic [PIX_W-1:0]       sat_dvs;
    logic [DIVIDEND_W-1:0]  hue_quo;
    logic [DIVIDEND_W-1:0]  sat_quo;
    logic                   hue_done;
    logic                   sat_done;
    logic                   sec_g_q;
    logic                   sec_b_q;
    logic                   dir_q;
    logic [PIX_W-1:0]       max_q;
    logic [HUE_ANGLE_W-1:0] base;
    logic [HUE_ANGLE_W-1:0] angle;
    logic [2*PIX_W-1:0]     hue_prod;

    //////////////////////////////////////////////////
    // capture

    always_ff @(posedge clk_sys) begin
        if (load_r) begin
            r_q <= in_data;
        end
        if (load_g) begin
            g_q <= in_data;
        end
        if (load_b) begin
            b_q <= in_data;
        end
    end

    // both dividers start the cycle after B
    always_ff @(posedge clk_sys or negedge reset_sys) begin
        if (!reset_sys) begin
            start <= 1'b0;
        end else begin
            start <= load_b;
        end
    end

    //////////////////////////////////////////////////
    // max, min and dividends

    // ties go to red first and green next
    assign max_is_r = (r_q >= g_q) && (r_q >= b_q);
    assign max_is_g = !max_is_r && (g_q >= b_q);
    assign max_c    = max_is_r ? r_q : (max_is_g ? g_q : b_q);
    assign min_c    = ((r_q <= g_q) && (r_q <= b_q)) ? r_q : ((g_q <= b_q) ? g_q : b_q);
    assign range    = max_c - min_c;

    // difference of the two colours other than the max
    always_comb begin
        if (max_is_r) begin
            dir      = g_q >= b_q;
            diff_abs = dir ? g_q - b_q : b_q - g_q;
        end else if (max_is_g) begin
            dir      = b_q >= r_q;
            diff_abs = dir ? b_q - r_q : r_q - b_q;
        end else begin
            dir      = r_q >= g_q;
            diff_abs = dir ? r_q - g_q : g_q - r_q;
        end
    end

    // grey gives 0/1 so the hue quotient is zero
    assign hue_dvd = (range == '0) ? '0 : DIVIDEND_W'(diff_abs) * DIVIDEND_W'(HUE_SECTOR);
    assign hue_dvs = (range == '0) ? PIX_W'(1) : range;
    assign sat_dvd = DIVIDEND_W'(range) * DIVIDEND_W'(SAT_SCALE);
    assign sat_dvs = (max_c == '0) ? PIX_W'(1) : max_c;

    serial_divider i_hue_div (
        .clk_sys   (clk_sys),
        .reset_sys (reset_sys),
        .start     (start),
        .dividend  (hue_dvd),
        .divisor   (hue_dvs),
        .quotient  (hue_quo),
        .done      (hue_done)
    );

    serial_divider i_sat_div (
        .clk_sys   (clk_sys),
        .reset_sys (reset_sys),
        .start     (start),
        .dividend  (sat_dvd),
        .divisor   (sat_dvs),
        .quotient  (sat_quo),
        .done      (sat_done)
    );

    // the next pixel may overwrite r_q before the dividers finish
    always_ff @(posedge clk_sys) begin
        if (start) begin
            sec_g_q <= max_is_g;
            sec_b_q <= !max_is_r && !max_is_g;
            dir_q   <= dir;
            max_q   <= max_c;
        end
    end

    //////////////////////////////////////////////////
    // hue post-processing and results

    // red sector counts down from 360 when B > G
    assign base = sec_g_q ? HUE_G_BASE :
                  sec_b_q ? HUE_B_BASE :
                  (dir_q ? '0 : HUE_FULL);
    assign angle = dir_q ? base + hue_quo[HUE_ANGLE_W-1:0] : base - hue_quo[HUE_ANGLE_W-1:0];
    assign hue_prod = (2*PIX_W)'(angle) * (2*PIX_W)'(HUE_Q_COEF);

    always_ff @(posedge clk_sys) begin
        if (hue_done) begin
            hue <= hue_prod[2*PIX_W-1:PIX_W];
        end
        if (sat_done) begin
            sat <= sat_quo[PIX_W-1:0];
            val <= max_q;
        end
    end

    // hue quotient never leaves one sector
    a_hue_quo_range : assert property (
        @(posedge clk_sys) disable iff (!reset_sys)
        hue_done |-> hue_quo <= DIVIDEND_W'(HUE_SECTOR)
    );

    // saturation quotient fits one byte
    a_sat_quo_range : assert property (
        @(posedge clk_sys) disable iff (!reset_sys)
        sat_done |-> sat_quo <= DIVIDEND_W'(SAT_SCALE)
    );

endmodule

//--- logic/hsv_pkg.sv
package hsv_pkg;

    //////////////////////////////////////////////////
    // widths

    // one colour byte or one H, S or V byte
    localparam int PIX_W = 8;
    // scaled dividend and quotient
    localparam int DIVIDEND_W = 16;
    // hue angle in degrees up to 360
    localparam int HUE_ANGLE_W = 9;

    //////////////////////////////////////////////////
    // timing

    // one quotient bit per cycle
    localparam int DIV_CYCLES = 16;
    // capture, start, divide, result, mux
    localparam int PIPE_LATENCY = DIV_CYCLES + 5;
    localparam int LANES_DEFAULT = 6;

    //////////////////////////////////////////////////
    // hue and saturation constants

    localparam logic [PIX_W-1:0] HUE_SECTOR = 8'd60;
    localparam logic [HUE_ANGLE_W-1:0] HUE_G_BASE = 9'd120;
    localparam logic [HUE_ANGLE_W-1:0] HUE_B_BASE = 9'd240;
    localparam logic [HUE_ANGLE_W-1:0] HUE_FULL = 9'd360;
    // 255/360 in 8.8 fixed point
    localparam logic [PIX_W-1:0] HUE_Q_COEF = 8'd181;
    localparam logic [PIX_W-1:0] SAT_SCALE = 8'd255;

endpackage

//--- logic/hsv_stream_ctrl.sv
`timescale 1ns/100ps

module hsv_stream_ctrl #(
    parameter int NUM_LANES = hsv_pkg::LANES_DEFAULT
) (
    input  logic                                     clk_sys,
    input  logic                                     reset_sys,
    input  logic                                     in_vsync,
    input  logic                                     in_hsync,
    input  logic                                     in_en,
    output logic [NUM_LANES-1:0]                     load_r,
    output logic [NUM_LANES-1:0]                     load_g,
    output logic [NUM_LANES-1:0]                     load_b,
    input  logic [NUM_LANES-1:0][hsv_pkg::PIX_W-1:0] lane_hue,
    input  logic [NUM_LANES-1:0][hsv_pkg::PIX_W-1:0] lane_sat,
    input  logic [NUM_LANES-1:0][hsv_pkg::PIX_W-1:0] lane_val,
    output logic                                     out_vsync,
    output logic                                     out_hsync,
    output logic                                     out_en,
    output logic [hsv_pkg::PIX_W-1:0]                out_data
);
    import hsv_pkg::*;

    // bytes in one round of all lanes
    localparam int GROUP = 3 * NUM_LANES;
    localparam int CNT_W = $clog2(GROUP);

    logic [CNT_W-1:0]        in_cnt;
    logic [CNT_W-1:0]        out_cnt;
    logic [PIPE_LATENCY-1:0] vsync_d;
    logic [PIPE_LATENCY-1:0] hsync_d;
    logic [PIPE_LATENCY-1:0] en_d;

    //////////////////////////////////////////////////
    // input side

    always_ff @(posedge clk_sys or negedge reset_sys) begin
        if (!reset_sys) begin
            in_cnt <= '0;
        end else if (in_en) begin
            in_cnt <= (in_cnt == CNT_W'(GROUP - 1)) ? '0 : in_cnt + 1'b1;
        end
    end

    // lane k owns byte positions 3k, 3k+1, 3k+2
    for (genvar k = 0; k < NUM_LANES; k++) begin : g_load
        assign load_r[k] = in_en && (in_cnt == CNT_W'(3 * k));
        assign load_g[k] = in_en && (in_cnt == CNT_W'(3 * k + 1));
        assign load_b[k] = in_en && (in_cnt == CNT_W'(3 * k + 2));
    end

    //////////////////////////////////////////////////
    // framing delay line

    always_ff @(posedge clk_sys or negedge reset_sys) begin
        if (!reset_sys) begin
            vsync_d <= '0;
            hsync_d <= '0;
            en_d    <= '0;
        end else begin
            vsync_d <= {vsync_d[PIPE_LATENCY-2:0], in_vsync};
            hsync_d <= {hsync_d[PIPE_LATENCY-2:0], in_hsync};
            en_d    <= {en_d[PIPE_LATENCY-2:0], in_en};
        end
    end

    assign out_vsync = vsync_d[PIPE_LATENCY-1];
    assign out_hsync = hsync_d[PIPE_LATENCY-1];
    assign out_en    = en_d[PIPE_LATENCY-1];

    //////////////////////////////////////////////////
    // output side

    // mirrors in_cnt, shifted by the pipeline latency
    always_ff @(posedge clk_sys or negedge reset_sys) begin
        if (!reset_sys) begin
            out_cnt <= '0;
        end else if (out_en) begin
            out_cnt <= (out_cnt == CNT_W'(GROUP - 1)) ? '0 : out_cnt + 1'b1;
        end
    end

    // H, S, V of lane 0, then lane 1, ...
    always_comb begin
        out_data = '0;
        for (int k = 0; k < NUM_LANES; k++) begin
            if (out_cnt == CNT_W'(3 * k)) begin
                out_data = lane_hue[k];
            end
            if (out_cnt == CNT_W'(3 * k + 1)) begin
                out_data = lane_sat[k];
            end
            if (out_cnt == CNT_W'(3 * k + 2)) begin
                out_data = lane_val[k];
            end
        end
    end

    // a lane captures its bytes on consecutive cycles, so no gap inside a pixel
    a_pixel_unbroken : assert property (
        @(posedge clk_sys) disable iff (!reset_sys)
        (in_en && (in_cnt % 3 != 2)) |=> in_en
    );

endmodule

//--- logic/rgb2hsv.sv
`timescale 1ns/100ps

module rgb2hsv #(
    parameter int NUM_LANES = hsv_pkg::LANES_DEFAULT
) (
    input  logic                      clk_sys,
    input  logic                      reset_sys,
    input  logic                      in_vsync,
    input  logic                      in_hsync,
    input  logic                      in_en,
    input  logic [hsv_pkg::PIX_W-1:0] in_data,
    output logic                      out_vsync,
    output logic                      out_hsync,
    output logic                      out_en,
    output logic [hsv_pkg::PIX_W-1:0] out_data
);
    import hsv_pkg::*;

    logic [NUM_LANES-1:0]            load_r;
    logic [NUM_LANES-1:0]            load_g;
    logic [NUM_LANES-1:0]            load_b;
    logic [NUM_LANES-1:0][PIX_W-1:0] lane_hue;
    logic [NUM_LANES-1:0][PIX_W-1:0] lane_sat;
    logic [NUM_LANES-1:0][PIX_W-1:0] lane_val;

    // byte counting, sync delay and output mux
    hsv_stream_ctrl #(
        .NUM_LANES (NUM_LANES)
    ) i_ctrl (
        .clk_sys   (clk_sys),
        .reset_sys (reset_sys),
        .in_vsync  (in_vsync),
        .in_hsync  (in_hsync),
        .in_en     (in_en),
        .load_r    (load_r),
        .load_g    (load_g),
        .load_b    (load_b),
        .lane_hue  (lane_hue),
        .lane_sat  (lane_sat),
        .lane_val  (lane_val),
        .out_vsync (out_vsync),
        .out_hsync (out_hsync),
        .out_en    (out_en),
        .out_data  (out_data)
    );

    // pixels dealt round-robin, one lane per pixel slot
    for (genvar k = 0; k < NUM_LANES; k++) begin : g_lane
        hsv_lane i_lane (
            .clk_sys   (clk_sys),
            .reset_sys (reset_sys),
            .in_data   (in_data),
            .load_r    (load_r[k]),
            .load_g    (load_g[k]),
            .load_b    (load_b[k]),
            .hue       (lane_hue[k]),
            .sat       (lane_sat[k]),
            .val       (lane_val[k])
        );
    end

endmodule

//--- logic/serial_divider.sv
`timescale 1ns/100ps

module serial_divider (
    input  logic                           clk_sys,
    input  logic                           reset_sys,
    input  logic                           start,
    input  logic [hsv_pkg::DIVIDEND_W-1:0] dividend,
    input  logic [hsv_pkg::PIX_W-1:0]      divisor,
    output logic [hsv_pkg::DIVIDEND_W-1:0] quotient,
    output logic                           done
);
    import hsv_pkg::*;

    localparam int CNT_W = $clog2(DIV_CYCLES);

    logic                  busy;
    logic [CNT_W-1:0]      bit_cnt;
    logic [PIX_W-1:0]      rem_q;
    logic [PIX_W-1:0]      div_q;
    logic [DIVIDEND_W-1:0] quo_q;
    logic [PIX_W:0]        partial;
    logic [PIX_W:0]        trial;
    logic                  fits;

    // shift next dividend bit into the remainder and try a subtract
    assign partial  = {rem_q, quo_q[DIVIDEND_W-1]};
    assign trial    = partial - {1'b0, div_q};
    assign fits     = partial >= {1'b0, div_q};
    assign quotient = quo_q;

    always_ff @(posedge clk_sys or negedge reset_sys) begin
        if (!reset_sys) begin
            busy    <= 1'b0;
            bit_cnt <= '0;
            done    <= 1'b0;
        end else begin
            done <= 1'b0;
            if (start) begin
                busy    <= 1'b1;
                bit_cnt <= '0;
            end else if (busy) begin
                bit_cnt <= bit_cnt + 1'b1;
                // last quotient bit lands together with done
                if (bit_cnt == CNT_W'(DIV_CYCLES - 1)) begin
                    busy <= 1'b0;
                    done <= 1'b1;
                end
            end
        end
    end

    // dividend bits leave at the top as quotient bits enter at the bottom
    always_ff @(posedge clk_sys) begin
        if (start) begin
            rem_q <= '0;
            div_q <= divisor;
            quo_q <= dividend;
        end else if (busy) begin
            rem_q <= fits ? trial[PIX_W-1:0] : partial[PIX_W-1:0];
            quo_q <= {quo_q[DIVIDEND_W-2:0], fits};
        end
    end

    a_no_restart_busy : assert property (
        @(posedge clk_sys) disable iff (!reset_sys)
        start |-> !busy
    );

endmodule

//--- sim/tb_hsv_model.svh
`ifndef TB_HSV_MODEL_SVH
`define TB_HSV_MODEL_SVH

//////////////////////////////////////////////////
// random source

logic [31:0] lfsr_state = 32'h91fe856d;

// right-shift Galois form, taps 32, 22, 2, 1
function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
endfunction

// one LFSR step per bit taken
function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
        v = {v[30:0], lfsr_state[0]};
        lfsr_state = lfsr_step(lfsr_state);
    end
    return v;
endfunction

//////////////////////////////////////////////////
// reference conversion, returns {h, s, v}

function automatic logic [23:0] hsv_ref(input logic [7:0] r, input logic [7:0] g,
                                        input logic [7:0] b);
    int ri;
    int gi;
    int bi;
    int mx;
    int mn;
    int d;
    int up;
    int dn;
    int base;
    int ang;
    int h;
    int s;
    ri = int'(r);
    gi = int'(g);
    bi = int'(b);
    mx = (ri >= gi && ri >= bi) ? ri : ((gi >= bi) ? gi : bi);
    mn = (ri <= gi && ri <= bi) ? ri : ((gi <= bi) ? gi : bi);
    d = mx - mn;
    ang = 0;
    if (d != 0) begin
        // red checked first, then green
        if (mx == ri) begin
            up = gi;
            dn = bi;
            base = 0;
        end else if (mx == gi) begin
            up = bi;
            dn = ri;
            base = 120;
        end else begin
            up = ri;
            dn = gi;
            base = 240;
        end
        if (up >= dn) begin
            ang = base + 60 * (up - dn) / d;
        end else begin
            ang = ((base == 0) ? 360 : base) - 60 * (dn - up) / d;
        end
    end
    h = ang * 181 / 256;
    s = (mx == 0) ? 0 : d * 255 / mx;
    return {h[7:0], s[7:0], mx[7:0]};
endfunction

// fixed pixels, one word per row: R, G, B, idle cycles after
localparam int NUM_FIXED = 14;
logic [31:0] fixed_rows [NUM_FIXED] = '{
    32'hff_00_00_00, 32'h00_ff_00_00, 32'h00_00_ff_00, 32'hff_ff_00_00,
    32'h00_ff_ff_00, 32'hff_00_ff_00, 32'h80_80_80_00, 32'h00_00_00_00,
    32'hff_ff_ff_00, 32'hff_00_01_00, 32'hc8_0a_14_00, 32'hff_80_00_00,
    32'h0a_c8_64_00, 32'h64_32_c8_00
};

`endif

//--- sim/tb_rgb2hsv.sv
`timescale 1ns/100ps

module tb_rgb2hsv;
    import hsv_pkg::*;

    `include "tb_hsv_model.svh"

    logic             clk_sys = 1'b0;
    logic             reset_sys;
    logic             in_vsync;
    logic             in_hsync;
    logic             in_en;
    logic [PIX_W-1:0] in_data;
    logic             out_vsync;
    logic             out_hsync;
    logic             out_en;
    logic [PIX_W-1:0] out_data;

    // stimulus table, one word per row: R, G, B, idle cycles after
    logic [31:0]      rows [$];
    logic [PIX_W-1:0] exp_q [$];
    int               in_cyc_q [$];
    logic [2:0]       flag_q [$];
    int               cycle = 0;
    int               cycle_limit = 1000;
    int               checks = 0;
    int               idle_errs = 0;
    int               data_errs = 0;
    int               timing_errs = 0;

    rgb2hsv #(
        .NUM_LANES (LANES_DEFAULT)
    ) i_dut (
        .clk_sys   (clk_sys),
        .reset_sys (reset_sys),
        .in_vsync  (in_vsync),
        .in_hsync  (in_hsync),
        .in_en     (in_en),
        .in_data   (in_data),
        .out_vsync (out_vsync),
        .out_hsync (out_hsync),
        .out_en    (out_en),
        .out_data  (out_data)
    );

    always #50 clk_sys = ~clk_sys;

    //////////////////////////////////////////////////
    // driving

    task automatic drive_cycle(input logic vs, input logic hs, input logic en,
                               input logic [7:0] data);
        @(posedge clk_sys);
        #10;
        in_vsync = vs;
        in_hsync = hs;
        in_en    = en;
        in_data  = data;
    endtask

    // one hsync cycle, then the rows, then wait for the pipeline to drain
    task automatic run_rows(input int num, input string name, input int first,
                            input int last, input logic vs);
        logic [31:0] row;
        logic [23:0] hsv;
        int          errs_before;
        errs_before = data_errs;
        drive_cycle(vs, 1'b1, 1'b0, 8'h00);
        for (int i = first; i <= last; i++) begin
            row = rows[i];
            hsv = hsv_ref(row[31:24], row[23:16], row[15:8]);
            exp_q.push_back(hsv[23:16]);
            exp_q.push_back(hsv[15:8]);
            exp_q.push_back(hsv[7:0]);
            drive_cycle(1'b0, 1'b0, 1'b1, row[31:24]);
            drive_cycle(1'b0, 1'b0, 1'b1, row[23:16]);
            drive_cycle(1'b0, 1'b0, 1'b1, row[15:8]);
            repeat (row[7:0]) drive_cycle(1'b0, 1'b0, 1'b0, 8'h00);
        end
        drive_cycle(1'b0, 1'b0, 1'b0, 8'h00);
        while (exp_q.size() != 0) @(posedge clk_sys);
        $display("test %0d %s: %0d errors", num, name, data_errs - errs_before);
    endtask

    //////////////////////////////////////////////////
    // monitor and timeout

    always @(posedge clk_sys) begin : monitor
        logic [2:0] exp_flags;
        logic [7:0] exp_byte;
        int         in_cyc;
        cycle = cycle + 1;
        flag_q.push_back({in_vsync, in_hsync, in_en});
        if (in_en === 1'b1) begin
            in_cyc_q.push_back(cycle);
        end
        // outputs seen now belong to the inputs PIPE_LATENCY edges back
        if (flag_q.size() > PIPE_LATENCY) begin
            exp_flags = flag_q.pop_front();
            if (reset_sys === 1'b1 && {out_vsync, out_hsync, out_en} !== exp_flags) begin
                $display("MISMATCH {out_vsync,out_hsync,out_en}: got %h expected %h",
                         {out_vsync, out_hsync, out_en}, exp_flags);
                timing_errs++;
            end
        end
        if (reset_sys === 1'b1 && out_en === 1'b1) begin
            if (exp_q.size() == 0) begin
                $display("output byte %h came out with no pixel pending", out_data);
                data_errs++;
            end else begin
                exp_byte = exp_q.pop_front();
                in_cyc   = in_cyc_q.pop_front();
                checks++;
                if (out_data !== exp_byte) begin
                    $display("MISMATCH out_data: got %h expected %h", out_data, exp_byte);
                    data_errs++;
                end
                if (cycle - in_cyc != PIPE_LATENCY) begin
                    $display("output byte came %0d cycles after its input byte",
                             cycle - in_cyc);
                    timing_errs++;
                end
            end
        end
    end

    always @(negedge clk_sys) begin
        if (cycle > cycle_limit) begin
            $display("run stopped at cycle %0d with %0d bytes still pending",
                     cycle, exp_q.size());
            $display("Errors found");
            $finish;
        end
    end

    //////////////////////////////////////////////////
    // test sequence

    initial begin : stimulus
        logic [31:0] pix;
        logic [31:0] gap;
        int          busy_cycles;
        reset_sys = 1'b0;
        in_vsync  = 1'b0;
        in_hsync  = 1'b0;
        in_en     = 1'b0;
        in_data   = '0;

        for (int i = 0; i < NUM_FIXED; i++) begin
            rows.push_back(fixed_rows[i]);
        end
        for (int i = 0; i < 100; i++) begin
            pix = rand_bits(24);
            // last 40 rows get 0 to 7 idle cycles
            gap = (i < 60) ? 32'd0 : rand_bits(3);
            rows.push_back({pix[23:0], gap[7:0]});
        end
        busy_cycles = 0;
        foreach (rows[i]) begin
            busy_cycles += 3 + int'(rows[i][7:0]);
        end
        cycle_limit = 40 + busy_cycles + 3 * (2 * PIPE_LATENCY + 4) + 100;

        repeat (10) @(posedge clk_sys);
        #10;
        reset_sys = 1'b1;

        // no input yet, so nothing may come out
        repeat (30) begin
            @(posedge clk_sys);
            #10;
            checks++;
            if (out_en !== 1'b0 || out_vsync !== 1'b0 || out_hsync !== 1'b0) begin
                $display("output flags high before any input was given");
                idle_errs++;
            end
        end
        $display("test 1 idle after reset: %0d errors", idle_errs);

        run_rows(2, "fixed colours", 0, NUM_FIXED - 1, 1'b1);
        run_rows(3, "random back to back", NUM_FIXED, NUM_FIXED + 59, 1'b0);
        run_rows(4, "random with gaps", NUM_FIXED + 60, rows.size() - 1, 1'b0);
        repeat (PIPE_LATENCY + 2) drive_cycle(1'b0, 1'b0, 1'b0, 8'h00);
        $display("test 5 sync delay and byte latency: %0d errors", timing_errs);

        $display("5 tests, %0d checks, %0d errors", checks,
                 idle_errs + data_errs + timing_errs);
        if (idle_errs + data_errs + timing_errs == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule
